// File: Bender.yml
package:
  name: wb_top

sources:
  - hw/wb_pipe_pkg.sv
  - hw/csr_pkg.sv
  - hw/wb_stage.sv
  - hw/csr_file.sv
  - hw/regfile.sv
  - hw/wb_top.sv
  - target: test
    files:
      - dv/wb_checker.sv
      - dv/wb_top_tb.sv

// File: dv/wb_checker.sv
module wb_checker (
    input logic               clk,
    input logic               resetn,
    input logic               wb_valid,
    input logic               rf_we,
    input logic               trace_we,
    input csr_pkg::csr_req_t  csr_req,
    input csr_pkg::csr_ex_t   csr_ex,
    input csr_pkg::redirect_t redirect
);
    int fail_count = 0;

    // an exception kills its own register and CSR writes
    assert property (@(posedge clk) disable iff (!resetn)
        csr_ex.ex |-> !rf_we && !csr_req.we)
    else begin
        $error("register or CSR write committed under an exception");
        fail_count++;
    end

    // a flush needs a cause
    assert property (@(posedge clk) disable iff (!resetn)
        redirect.valid |-> csr_ex.ex || csr_ex.ertn)
    else begin
        $error("redirect raised without exception or ertn");
        fail_count++;
    end

    // first cycle out of reset is quiet
    assert property (@(posedge clk)
        $rose(resetn) |-> !wb_valid && !rf_we && !csr_req.we && !csr_ex.ex
                          && !csr_ex.ertn && !redirect.valid && !trace_we)
    else begin
        $error("commit output active right after reset");
        fail_count++;
    end

endmodule

bind wb_stage wb_checker stage_chk (
    .clk      (clk),
    .resetn   (resetn),
    .wb_valid (wb_valid),
    .rf_we    (rf_wr.we),
    .trace_we (trace.we),
    .csr_req  (csr_req),
    .csr_ex   (csr_ex),
    .redirect ('0)
);

bind csr_file wb_checker csr_chk (
    .clk      (clk),
    .resetn   (resetn),
    .wb_valid (1'b0),
    .rf_we    (1'b0),
    .trace_we (1'b0),
    .csr_req  (csr_req),
    .csr_ex   (csr_ex),
    .redirect (redirect)
);

// File: dv/wb_top_tb.sv
module wb_top_tb;
    import wb_pipe_pkg::*;
    import csr_pkg::*;

    typedef struct packed {
        logic                  valid;
        mem_to_wb_t            m;
        wb_fwd_t               fwd;
        wb_trace_t             trc;
        redirect_t             redir;
        logic [reg_addr_w-1:0] rd_addr;
        logic [xlen-1:0]       rd_val;
    } row_t;

    logic                  clk = 1'b0;
    logic                  resetn;
    logic                  mem_to_wb_valid;
    mem_to_wb_t            mem_to_wb;
    logic [reg_addr_w-1:0] raddr1;
    logic [reg_addr_w-1:0] raddr2;
    logic                  wb_allowin;
    logic [xlen-1:0]       rdata1;
    logic [xlen-1:0]       rdata2;
    wb_fwd_t               wb_fwd;
    wb_trace_t             trace;
    redirect_t             redirect;

    row_t        rows[$];
    int          row_fails[];
    int          errors = 0;
    int          rows_failed = 0;
    int          cycles = 0;
    int          limit = 0;
    logic [31:0] lfsr_q;
    logic [31:0] pc_q;

    // reference model of registers and CSRs
    logic [31:0] regs_m [32];
    logic [31:0] crmd_m;
    logic [31:0] prmd_m;
    logic [31:0] estat_m;
    logic [31:0] era_m;
    logic [31:0] eentry_m;
    logic [31:0] save_m [4];

    wb_top wb_top_i (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout after %0d cycles, rows did not finish", limit);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] merge(input logic [31:0] old, val, mask);
        return (old & ~mask) | (val & mask);
    endfunction

    function automatic logic [31:0] csr_model_read(input logic [13:0] num);
        case (num)
            csr_crmd:   return crmd_m;
            csr_prmd:   return prmd_m;
            csr_estat:  return estat_m;
            csr_era:    return era_m;
            csr_eentry: return eentry_m;
            csr_save0, csr_save1, csr_save2, csr_save3: return save_m[num[1:0]];
            default:    return 32'h0;
        endcase
    endfunction

    // only architecturally writable fields take the merge
    task automatic csr_model_write(input logic [13:0] num, input logic [31:0] wm, wv);
        case (num)
            csr_crmd:   crmd_m = merge(crmd_m, wv, wm & 32'h0000_01ff);
            csr_prmd:   prmd_m = merge(prmd_m, wv, wm & 32'h0000_0007);
            csr_estat:  estat_m = merge(estat_m, wv, wm & 32'h0000_0003);
            csr_era:    era_m = merge(era_m, wv, wm);
            csr_eentry: eentry_m = merge(eentry_m, wv, wm & 32'hffff_ffc0);
            csr_save0, csr_save1, csr_save2, csr_save3:
                save_m[num[1:0]] = merge(save_m[num[1:0]], wv, wm);
            default: ;
        endcase
    endtask

    function automatic mem_to_wb_t alu_entry(input logic [4:0] rd);
        mem_to_wb_t m;
        m = '0;
        m.pc = pc_q;
        m.rf_we = 1'b1;
        m.rf_waddr = rd;
        m.rf_wdata = rand_bits(32);
        pc_q = pc_q + 32'd4;
        return m;
    endfunction

    function automatic mem_to_wb_t csr_entry(input logic [13:0] num, input logic [4:0] rd,
                                             input logic we, input logic [31:0] wm, wv);
        mem_to_wb_t m;
        m = alu_entry(rd);
        m.csr_re = 1'b1;
        m.csr_we = we;
        m.csr_num = num;
        m.csr_wmask = wm;
        m.csr_wvalue = wv;
        return m;
    endfunction

    // expected outputs first, then the state update at the end of the WB cycle
    task automatic add_row(input logic valid, input mem_to_wb_t m);
        row_t r;
        logic ex;
        logic er;
        ex = valid & m.ex_en;
        er = valid & m.ertn;
        r.valid = valid;
        r.m = m;
        r.fwd.we = valid & m.rf_we & ~m.ex_en;
        r.fwd.waddr = m.rf_waddr;
        r.fwd.wdata = m.csr_re ? csr_model_read(m.csr_num) : m.rf_wdata;
        r.trc.pc = m.pc;
        r.trc.we = r.fwd.we;
        r.trc.wnum = m.rf_waddr;
        r.trc.wdata = r.fwd.wdata;
        r.redir.valid = ex | er;
        r.redir.target = ex ? eentry_m : era_m;
        if (ex) begin
            prmd_m[2:0] = crmd_m[2:0];
            crmd_m[2:0] = 3'b0;
            era_m = m.pc;
            estat_m[21:16] = m.ecode;
            estat_m[30:22] = m.esubcode;
        end else if (er) begin
            crmd_m[2:0] = prmd_m[2:0];
        end else if (valid && m.csr_we) begin
            csr_model_write(m.csr_num, m.csr_wmask, m.csr_wvalue);
        end
        if (r.fwd.we && m.rf_waddr != 5'd0) begin
            regs_m[m.rf_waddr] = r.fwd.wdata;
        end
        r.rd_addr = m.rf_waddr;
        r.rd_val = regs_m[m.rf_waddr];
        rows.push_back(r);
    endtask

    task automatic build_table();
        mem_to_wb_t m;
        add_row(1'b1, alu_entry(5'd5));
        add_row(1'b1, alu_entry(5'd0));
        m = alu_entry(5'd5);
        m.csr_we = 1'b1;
        m.csr_num = csr_save0;
        m.csr_wmask = '1;
        m.csr_wvalue = rand_bits(32);
        m.ex_en = 1'b1;
        add_row(1'b0, m);
        add_row(1'b1, csr_entry(csr_save1, 5'd6, 1'b1, '1, rand_bits(32)));
        add_row(1'b1, csr_entry(csr_save1, 5'd7, 1'b0, '0, '0));
        add_row(1'b1, csr_entry(csr_save1, 5'd8, 1'b1, rand_bits(32), rand_bits(32)));
        add_row(1'b1, csr_entry(csr_save1, 5'd9, 1'b0, '0, '0));
        add_row(1'b1, csr_entry(csr_eentry, 5'd10, 1'b1, '1, rand_bits(32)));
        add_row(1'b1, csr_entry(csr_crmd, 5'd11, 1'b1, 32'h7, 32'h7));
        // bubble carrying register and SAVE0 writes without an exception
        m.ex_en = 1'b0;
        add_row(1'b0, m);
        add_row(1'b1, csr_entry(csr_save0, 5'd19, 1'b0, '0, '0));
        // syscall with a suppressed SAVE2 write
        m = csr_entry(csr_save2, 5'd12, 1'b1, '1, rand_bits(32));
        m.ex_en = 1'b1;
        m.ecode = ecode_sys;
        m.esubcode = 9'(rand_bits(9));
        add_row(1'b1, m);
        add_row(1'b1, csr_entry(csr_era, 5'd13, 1'b0, '0, '0));
        add_row(1'b1, csr_entry(csr_estat, 5'd14, 1'b0, '0, '0));
        add_row(1'b1, csr_entry(csr_crmd, 5'd15, 1'b0, '0, '0));
        add_row(1'b1, csr_entry(csr_prmd, 5'd16, 1'b0, '0, '0));
        add_row(1'b1, csr_entry(csr_save2, 5'd17, 1'b0, '0, '0));
        m = alu_entry(5'd0);
        m.rf_we = 1'b0;
        m.ertn = 1'b1;
        add_row(1'b1, m);
        add_row(1'b1, csr_entry(csr_crmd, 5'd18, 1'b0, '0, '0));
        add_row(1'b1, alu_entry(5'd5));
    endtask

    task automatic check_word(input logic [31:0] got, exp, input string name);
        if (got !== exp) begin
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // address and data only matter when a write retires
    task automatic check_fwd(input wb_fwd_t got, exp);
        check_word(32'(got.we), 32'(exp.we), "wb_fwd.we");
        if (exp.we) begin
            check_word(32'(got.waddr), 32'(exp.waddr), "wb_fwd.waddr");
            check_word(got.wdata, exp.wdata, "wb_fwd.wdata");
        end
    endtask

    task automatic check_trace(input wb_trace_t got, exp);
        check_word(32'(got.we), 32'(exp.we), "trace.we");
        if (exp.we) begin
            check_word(got.pc, exp.pc, "trace.pc");
            check_word(32'(got.wnum), 32'(exp.wnum), "trace.wnum");
            check_word(got.wdata, exp.wdata, "trace.wdata");
        end
    endtask

    task automatic check_redirect(input redirect_t got, exp);
        check_word(32'(got.valid), 32'(exp.valid), "redirect.valid");
        if (exp.valid) begin
            check_word(got.target, exp.target, "redirect.target");
        end
    endtask

    initial begin
        int n;
        int e0;
        int chk;
        resetn = 1'b0;
        mem_to_wb_valid = 1'b0;
        mem_to_wb = '0;
        raddr1 = '0;
        raddr2 = '0;
        lfsr_q = 32'h7a56_6e56;
        pc_q = 32'h1c00_0000;
        regs_m = '{default: '0};
        save_m = '{default: '0};
        crmd_m = 32'h8;
        prmd_m = '0;
        estat_m = '0;
        era_m = '0;
        eentry_m = '0;
        build_table();
        n = rows.size();
        row_fails = new[n];
        limit = n * 4 + 20;
        repeat (5) @(negedge clk);
        resetn = 1'b1;
        // row i drives, row i-1 sits in WB, row i-2 has written back
        for (int i = 0; i < n + 2; i++) begin
            @(negedge clk);
            check_word(32'(wb_allowin), 32'd1, "wb_allowin");
            if (i >= 2) begin
                e0 = errors;
                check_word(rdata1, rows[i-2].rd_val, "rdata1");
                check_word(rdata2, rows[i-2].rd_val, "rdata2");
                row_fails[i-2] += errors - e0;
                if (row_fails[i-2] != 0) begin
                    rows_failed++;
                end
                $display("row %0d valid %0b: %0d mismatches", i - 2, rows[i-2].valid,
                         row_fails[i-2]);
            end
            if (i >= 1) begin
                e0 = errors;
                check_fwd(wb_fwd, rows[i-1].fwd);
                check_trace(trace, rows[i-1].trc);
                check_redirect(redirect, rows[i-1].redir);
                row_fails[i-1] += errors - e0;
                raddr1 = rows[i-1].rd_addr;
                raddr2 = rows[i-1].rd_addr;
            end
            mem_to_wb_valid = (i < n) ? rows[i].valid : 1'b0;
            if (i < n) begin
                mem_to_wb = rows[i].m;
            end
        end
        chk = wb_top_i.wb_stage_i.stage_chk.fail_count
            + wb_top_i.csr_file_i.csr_chk.fail_count;
        $display("rows %0d, failed %0d, mismatches %0d, assertion failures %0d",
                 n, rows_failed, errors, chk);
        if (errors == 0 && chk == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: hw/csr_file.sv
module csr_file (
    input  logic                         clk,
    input  logic                         resetn,
    input  csr_pkg::csr_req_t            csr_req,
    input  csr_pkg::csr_ex_t             csr_ex,
    output logic [wb_pipe_pkg::xlen-1:0] csr_rvalue,
    output csr_pkg::redirect_t           redirect
);
    import wb_pipe_pkg::*;
    import csr_pkg::*;

    // CRMD fields
    logic [1:0] crmd_plv;
    logic       crmd_ie;
    logic       crmd_da;
    logic       crmd_pg;
    logic [1:0] crmd_datf;
    logic [1:0] crmd_datm;

    // PRMD fields
    logic [1:0] prmd_pplv;
    logic       prmd_pie;

    // ESTAT fields, only the software interrupt bits are writable
    logic [1:0] estat_is_sw;
    logic [5:0] estat_ecode;
    logic [8:0] estat_esubcode;

    logic [xlen-1:0] era;
    logic [25:0]     eentry_va;
    logic [xlen-1:0] save_q [4];

    logic [xlen-1:0] wdata_m;
    logic            wr_save;

    // read mux, unknown numbers read zero
    always_comb begin
        case (csr_req.num)
            csr_crmd:   csr_rvalue = {23'b0, crmd_datm, crmd_datf, crmd_pg, crmd_da,
                                      crmd_ie, crmd_plv};
            csr_prmd:   csr_rvalue = {29'b0, prmd_pie, prmd_pplv};
            csr_estat:  csr_rvalue = {1'b0, estat_esubcode, estat_ecode, 14'b0,
                                      estat_is_sw};
            csr_era:    csr_rvalue = era;
            csr_eentry: csr_rvalue = {eentry_va, 6'b0};
            csr_save0:  csr_rvalue = save_q[0];
            csr_save1:  csr_rvalue = save_q[1];
            csr_save2:  csr_rvalue = save_q[2];
            csr_save3:  csr_rvalue = save_q[3];
            default:    csr_rvalue = '0;
        endcase
    end

    // merge through the mask against the current value of the same CSR
    assign wdata_m = (csr_rvalue & ~csr_req.wmask) | (csr_req.wvalue & csr_req.wmask);

    assign wr_save = csr_req.we && (csr_req.num[13:2] == csr_save0[13:2]);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd_plv  <= 2'b0;
            crmd_ie   <= 1'b0;
            crmd_da   <= 1'b1;
            crmd_pg   <= 1'b0;
            crmd_datf <= 2'b0;
            crmd_datm <= 2'b0;
        end else if (csr_ex.ex) begin
            crmd_plv <= 2'b0;
            crmd_ie  <= 1'b0;
        end else if (csr_ex.ertn) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (csr_req.we && csr_req.num == csr_crmd) begin
            crmd_plv  <= wdata_m[1:0];
            crmd_ie   <= wdata_m[2];
            crmd_da   <= wdata_m[3];
            crmd_pg   <= wdata_m[4];
            crmd_datf <= wdata_m[6:5];
            crmd_datm <= wdata_m[8:7];
        end
    end

    // exception saves the previous mode
    always_ff @(posedge clk) begin
        if (!resetn) begin
            prmd_pplv <= 2'b0;
            prmd_pie  <= 1'b0;
        end else if (csr_ex.ex) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (csr_req.we && csr_req.num == csr_prmd) begin
            prmd_pplv <= wdata_m[1:0];
            prmd_pie  <= wdata_m[2];
        end
    end

    // ecode and esubcode are read only to software
    always_ff @(posedge clk) begin
        if (!resetn) begin
            estat_is_sw    <= 2'b0;
            estat_ecode    <= 6'b0;
            estat_esubcode <= 9'b0;
        end else if (csr_ex.ex) begin
            estat_ecode    <= csr_ex.ecode;
            estat_esubcode <= csr_ex.esubcode;
        end else if (csr_req.we && csr_req.num == csr_estat) begin
            estat_is_sw <= wdata_m[1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            era <= '0;
        end else if (csr_ex.ex) begin
            era <= csr_ex.pc;
        end else if (csr_req.we && csr_req.num == csr_era) begin
            era <= wdata_m;
        end
    end

    // entry point is 64-byte aligned
    always_ff @(posedge clk) begin
        if (!resetn) begin
            eentry_va <= '0;
        end else if (csr_req.we && csr_req.num == csr_eentry) begin
            eentry_va <= wdata_m[31:6];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < 4; i++) begin
                save_q[i] <= '0;
            end
        end else if (wr_save) begin
            save_q[csr_req.num[1:0]] <= wdata_m;
        end
    end

    // flush target, exception wins over ertn
    assign redirect.valid  = csr_ex.ex | csr_ex.ertn;
    assign redirect.target = csr_ex.ex ? {eentry_va, 6'b0} : era;

endmodule

// File: hw/csr_pkg.sv
package csr_pkg;

    // CSR numbers
    localparam logic [13:0] csr_crmd   = 14'h000;
    localparam logic [13:0] csr_prmd   = 14'h001;
    localparam logic [13:0] csr_estat  = 14'h005;
    localparam logic [13:0] csr_era    = 14'h006;
    localparam logic [13:0] csr_eentry = 14'h00c;
    localparam logic [13:0] csr_save0  = 14'h030;
    localparam logic [13:0] csr_save1  = 14'h031;
    localparam logic [13:0] csr_save2  = 14'h032;
    localparam logic [13:0] csr_save3  = 14'h033;

    // exception codes
    localparam logic [5:0] ecode_sys = 6'h0b;
    localparam logic [5:0] ecode_brk = 6'h0c;
    localparam logic [5:0] ecode_ine = 6'h0d;

    // CSR access from the writeback stage
    typedef struct packed {
        logic        re;
        logic        we;
        logic [13:0] num;
        logic [31:0] wmask;
        logic [31:0] wvalue;
    } csr_req_t;

    // exception and ertn commit
    typedef struct packed {
        logic        ex;
        logic        ertn;
        logic [5:0]  ecode;
        logic [8:0]  esubcode;
        logic [31:0] pc;
    } csr_ex_t;

    // flush toward fetch
    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } redirect_t;

endpackage

// File: hw/regfile.sv
module regfile (
    input  logic                               clk,
    input  logic                               resetn,
    input  logic [wb_pipe_pkg::reg_addr_w-1:0] raddr1,
    input  logic [wb_pipe_pkg::reg_addr_w-1:0] raddr2,
    input  wb_pipe_pkg::wb_fwd_t               wr,
    output logic [wb_pipe_pkg::xlen-1:0]       rdata1,
    output logic [wb_pipe_pkg::xlen-1:0]       rdata2
);
    import wb_pipe_pkg::*;

    logic [xlen-1:0] regs [rf_entries];

    // r0 is never written
    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < rf_entries; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.we && wr.waddr != '0) begin
            regs[wr.waddr] <= wr.wdata;
        end
    end

    // no bypass here, decode forwards from wb_fwd
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: hw/wb_pipe_pkg.sv
package wb_pipe_pkg;

    // register index and data widths
    localparam int reg_addr_w = 5;
    localparam int xlen       = 32;
    localparam int rf_entries = 1 << reg_addr_w;

    // one instruction handed over from MEM
    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic                  rf_we;
        logic [reg_addr_w-1:0] rf_waddr;
        logic [xlen-1:0]       rf_wdata;
        logic                  csr_re;
        logic                  csr_we;
        logic [13:0]           csr_num;
        logic [xlen-1:0]       csr_wmask;
        logic [xlen-1:0]       csr_wvalue;
        logic                  ertn;
        logic                  ex_en;
        logic [5:0]            ecode;
        logic [8:0]            esubcode;
    } mem_to_wb_t;

    // retiring register write, also the forwarding bus toward decode
    typedef struct packed {
        logic                  we;
        logic [reg_addr_w-1:0] waddr;
        logic [xlen-1:0]       wdata;
    } wb_fwd_t;

    // debug trace of each retired write
    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic                  we;
        logic [reg_addr_w-1:0] wnum;
        logic [xlen-1:0]       wdata;
    } wb_trace_t;

endpackage

// File: hw/wb_stage.sv
module wb_stage (
    input  logic                         clk,
    input  logic                         resetn,
    input  logic                         mem_to_wb_valid,
    input  wb_pipe_pkg::mem_to_wb_t      mem_to_wb,
    input  logic [wb_pipe_pkg::xlen-1:0] csr_rvalue,
    output logic                         wb_allowin,
    output csr_pkg::csr_req_t            csr_req,
    output csr_pkg::csr_ex_t             csr_ex,
    output wb_pipe_pkg::wb_fwd_t         rf_wr,
    output wb_pipe_pkg::wb_trace_t       trace
);
    import wb_pipe_pkg::*;

    logic            wb_valid;
    mem_to_wb_t      wb_q;
    logic            wb_ex;
    logic            wb_commit;
    logic [xlen-1:0] wb_wdata;

    // writeback never stalls
    assign wb_allowin = 1'b1;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else if (wb_allowin) begin
            wb_valid <= mem_to_wb_valid;
        end
    end

    // held entry, loaded only on an accepted handshake
    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_q <= '0;
        end else if (mem_to_wb_valid && wb_allowin) begin
            wb_q <= mem_to_wb;
        end
    end

    // an exception kills the architectural writes of its own instruction
    assign wb_ex     = wb_valid & wb_q.ex_en;
    assign wb_commit = wb_valid & ~wb_q.ex_en;

    // csrrd, csrwr and csrxchg all retire the old CSR value
    assign wb_wdata = wb_q.csr_re ? csr_rvalue : wb_q.rf_wdata;

    // CSR access
    assign csr_req.re     = wb_q.csr_re;
    assign csr_req.we     = wb_commit & wb_q.csr_we;
    assign csr_req.num    = wb_q.csr_num;
    assign csr_req.wmask  = wb_q.csr_wmask;
    assign csr_req.wvalue = wb_q.csr_wvalue;

    // exception and ertn commit
    assign csr_ex.ex       = wb_ex;
    assign csr_ex.ertn     = wb_valid & wb_q.ertn;
    assign csr_ex.ecode    = wb_q.ecode;
    assign csr_ex.esubcode = wb_q.esubcode;
    assign csr_ex.pc       = wb_q.pc;

    // register write, forwarded to decode from the top
    assign rf_wr.we    = wb_commit & wb_q.rf_we;
    assign rf_wr.waddr = wb_q.rf_waddr;
    assign rf_wr.wdata = wb_wdata;

    // trace follows the retiring write
    assign trace.pc    = wb_q.pc;
    assign trace.we    = rf_wr.we;
    assign trace.wnum  = wb_q.rf_waddr;
    assign trace.wdata = wb_wdata;

endmodule

// File: hw/wb_top.sv
module wb_top (
    input  logic                               clk,
    input  logic                               resetn,
    input  logic                               mem_to_wb_valid,
    input  wb_pipe_pkg::mem_to_wb_t            mem_to_wb,
    input  logic [wb_pipe_pkg::reg_addr_w-1:0] raddr1,
    input  logic [wb_pipe_pkg::reg_addr_w-1:0] raddr2,
    output logic                               wb_allowin,
    output logic [wb_pipe_pkg::xlen-1:0]       rdata1,
    output logic [wb_pipe_pkg::xlen-1:0]       rdata2,
    output wb_pipe_pkg::wb_fwd_t               wb_fwd,
    output wb_pipe_pkg::wb_trace_t             trace,
    output csr_pkg::redirect_t                 redirect
);
    import wb_pipe_pkg::*;
    import csr_pkg::*;

    csr_req_t        csr_req;
    csr_ex_t         csr_ex;
    logic [xlen-1:0] csr_rvalue;

    wb_stage wb_stage_i (
        .clk             (clk),
        .resetn          (resetn),
        .mem_to_wb_valid (mem_to_wb_valid),
        .mem_to_wb       (mem_to_wb),
        .csr_rvalue      (csr_rvalue),
        .wb_allowin      (wb_allowin),
        .csr_req         (csr_req),
        .csr_ex          (csr_ex),
        .rf_wr           (wb_fwd),
        .trace           (trace)
    );

    csr_file csr_file_i (
        .clk        (clk),
        .resetn     (resetn),
        .csr_req    (csr_req),
        .csr_ex     (csr_ex),
        .csr_rvalue (csr_rvalue),
        .redirect   (redirect)
    );

    // the retire bus doubles as the regfile write port
    regfile regfile_i (
        .clk    (clk),
        .resetn (resetn),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .wr     (wb_fwd),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

endmodule

// File: vlog.f
hw/wb_pipe_pkg.sv
hw/csr_pkg.sv
hw/wb_stage.sv
hw/csr_file.sv
hw/regfile.sv
hw/wb_top.sv
dv/wb_checker.sv
dv/wb_top_tb.sv
